// File: sim.f
design/alut_pkg.sv
design/alut_ifs.sv
design/alut_mem.sv
design/alut_age_checker.sv
design/alut_addr_checker.sv
design/alut_regs.sv
design/alut_top.sv
sim/alut_properties.sv
sim/alut_tb.sv

// File: Makefile
# Verilator build and run of the address lookup unit testbench

VERILATOR ?= verilator
TOP       ?= alut_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/alut_tb.sv
// testbench for the address lookup unit, checks over AXI4-Lite against a table model
`timescale 1ns/1ps

module alut_tb;

   localparam int          n_checks     = 18;
   localparam int          limit_cycles = 20 * n_checks * 40;
   localparam logic [47:0] own_mac      = 48'h0200_5e10_2030;   // switch address

   logic        pclk25 = 1'b0;
   logic        n_p_reset25;
   logic [7:0]  awaddr, araddr;
   logic        awvalid, awready, wvalid, wready, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;
   logic [31:0] wdata, rdata;
   logic [3:0]  wstrb;
   logic [1:0]  bresp, rresp;

   logic [31:0] lfsr_q = 32'hd06c3d94;
   logic        b_backpressure = 1'b1;   // random bready stalls allowed
   logic        ref_valid [256];       // table model with one slot per hash
   logic [47:0] ref_addr  [256];
   logic [1:0]  ref_port  [256];
   logic        exp_reused   = 1'b0;   // sticky until reg_reused is read
   logic [47:0] exp_inv_addr = '0;
   logic [1:0]  exp_inv_port = '0;

   string       name_q [$];            // pending compares
   logic [31:0] exp_q  [$];
   logic [31:0] got_q  [$];
   string       cmp_name;
   logic [31:0] cmp_exp, cmp_got;

   alut_top #(.table_depth(256)) uut (.*);

   always #2 pclk25 = ~pclk25;

   // ------------------------------------------------------------
   // random bits and reference model
   // ------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   task automatic rand_bits(input int n, output logic [47:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[46:0], lfsr_q[0]};   // one step per bit
      end
   endtask

   function automatic logic [7:0] hash8(input logic [47:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40];
   endfunction

   // expected d_port of one check and source learn into the model
   function automatic logic [4:0] ref_check(input logic [47:0] d, input logic [47:0] s,
                                            input logic [1:0] sp, input logic [47:0] mac,
                                            input logic stale, output logic reused,
                                            output logic [47:0] inv_addr,
                                            output logic [1:0] inv_port);
      logic [7:0] hd, hs;
      logic [4:0] src, dport;
      reused   = 1'b0;
      inv_addr = '0;
      inv_port = '0;
      if (d == mac)
         return alut_pkg::dport_mac;   // no lookup and no learn
      hd  = hash8(d);
      hs  = hash8(s);
      src = 5'd1 << sp;
      if (ref_valid[hd] && !stale && ref_addr[hd] == d)
         dport = (5'd1 << ref_port[hd]) & ~src;
      else
         dport = alut_pkg::dport_all & ~src;
      if (ref_valid[hs] && ref_addr[hs] != s)
      begin
         reused   = 1'b1;
         inv_addr = ref_addr[hs];
         inv_port = ref_port[hs];
      end
      ref_valid[hs] = 1'b1;
      ref_addr[hs]  = s;
      ref_port[hs]  = sp;
      return dport;
   endfunction

   task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
      name_q.push_back(name);
      exp_q.push_back(exp);
      got_q.push_back(got);
   endtask

   // compare process drains the queue filled just after the rising edge
   always @(negedge pclk25)
   begin
      while (name_q.size() > 0)
      begin
         cmp_name = name_q.pop_front();
         cmp_exp  = exp_q.pop_front();
         cmp_got  = got_q.pop_front();
         assert (cmp_got === cmp_exp)
         else
         begin
            $display("ERR %s expected %h actual %h", cmp_name, cmp_exp, cmp_got);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
         end
      end
   end

   // ------------------------------------------------------------
   // axi4-lite tasks that start and end 1 ns after a rising edge
   // ------------------------------------------------------------
   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
      logic [47:0] r;
      logic        done;
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'hf;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      #1;                               // let awready settle
      while (!awready)
      begin
         @(posedge pclk25);
         #2;
      end
      @(posedge pclk25);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      done    = 1'b0;
      while (!done)
      begin
         rand_bits(1, r);
         bready = r[0] | !b_backpressure;   // random back-pressure
         if (bvalid && bready)
         begin
            expect_eq("axi_bresp", 32'd0, {30'd0, bresp});
            done = 1'b1;
         end
         @(posedge pclk25);
         #1;
      end
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
      logic [47:0] r;
      logic        done;
      araddr  = addr;
      arvalid = 1'b1;
      #1;
      while (!arready)
      begin
         @(posedge pclk25);
         #2;
      end
      @(posedge pclk25);
      #1;
      arvalid = 1'b0;
      done    = 1'b0;
      while (!done)
      begin
         rand_bits(1, r);
         rready = r[0];
         if (rvalid && rready)
         begin
            data = rdata;
            expect_eq("axi_rresp", 32'd0, {30'd0, rresp});
            done = 1'b1;
         end
         @(posedge pclk25);
         #1;
      end
      rready = 1'b0;
   endtask

   // one frame check where twice sends a second command while busy
   task automatic run_check(input string name, input logic [47:0] d, input logic [47:0] s,
                            input logic [1:0] sp, input logic stale, input logic twice);
      logic [31:0] v;
      logic [4:0]  exp_dport;
      logic        r;
      logic [47:0] ia;
      logic [1:0]  ip;
      exp_dport = ref_check(d, s, sp, own_mac, stale, r, ia, ip);
      if (r)
      begin
         exp_reused   = 1'b1;
         exp_inv_addr = ia;
         exp_inv_port = ip;
      end
      axi_write(alut_pkg::reg_daddr_lo, d[31:0]);
      axi_write(alut_pkg::reg_daddr_hi, {16'd0, d[47:32]});
      axi_write(alut_pkg::reg_saddr_lo, s[31:0]);
      axi_write(alut_pkg::reg_saddr_hi, {16'd0, s[47:32]});
      axi_write(alut_pkg::reg_sport, {30'd0, sp});
      b_backpressure = !twice;   // prompt response puts the repeat inside the check
      axi_write(alut_pkg::reg_cmd, 32'd1);
      b_backpressure = 1'b1;
      if (twice)
         axi_write(alut_pkg::reg_cmd, 32'd1);
      v = 32'd1;
      while (v[0])
         axi_read(alut_pkg::reg_status, v);   // busy bit
      axi_read(alut_pkg::reg_dport, v);
      expect_eq(name, {27'd0, exp_dport}, v);
   endtask

   task automatic check_reused(input string name);
      logic [31:0] v;
      axi_read(alut_pkg::reg_reused, v);
      expect_eq(name, {31'd0, exp_reused}, v);
      exp_reused = 1'b0;   // read clears
   endtask

   task automatic check_inv();
      logic [31:0] v;
      axi_read(alut_pkg::reg_inv_lo, v);
      expect_eq("inv_addr_lo", exp_inv_addr[31:0], v);
      axi_read(alut_pkg::reg_inv_hi, v);
      expect_eq("inv_addr_hi", {16'd0, exp_inv_addr[47:32]}, v);
      axi_read(alut_pkg::reg_inv_port, v);
      expect_eq("inv_port", {30'd0, exp_inv_port}, v);
   endtask

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial
   begin : tests
      logic [47:0] a, b, d, r8, p;
      logic [31:0] v;
      n_p_reset25 = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      for (int i = 0; i < 256; i++)
         ref_valid[i] = 1'b0;
      repeat (10) @(posedge pclk25);
      #1;
      n_p_reset25 = 1'b1;

      axi_write(alut_pkg::reg_mac_lo, own_mac[31:0]);
      axi_write(alut_pkg::reg_mac_hi, {16'd0, own_mac[47:32]});
      axi_write(alut_pkg::reg_best_before, 32'hffff_ffff);
      axi_read(8'h40, v);
      expect_eq("unmapped_read", 32'd0, v);

      // frames for the switch itself leave the source unlearned
      run_check("mac_hit", own_mac, 48'h0a1b_2c3d_4e5f, 2'd1, 1'b0, 1'b0);
      run_check("mac_no_learn", 48'h0a1b_2c3d_4e5f, 48'h0011_2233_4455, 2'd2, 1'b0, 1'b0);
      run_check("unknown_dest", 48'h00aa_bbcc_ddee, 48'h0066_7788_99aa, 2'd0, 1'b0, 1'b0);

      // learned destination from another port and then the same port
      run_check("learn_a", 48'h0d00_0000_0001, 48'h0c00_0000_00a1, 2'd3, 1'b0, 1'b0);
      run_check("known_dest", 48'h0c00_0000_00a1, 48'h0e00_0000_00b2, 2'd0, 1'b0, 1'b0);
      run_check("same_port", 48'h0c00_0000_00a1, 48'h0f00_0000_00c3, 2'd3, 1'b0, 1'b0);

      // zero best before puts every stored entry out of date
      axi_write(alut_pkg::reg_best_before, 32'd0);
      run_check("learn_d", 48'h0000_0000_1234, 48'h1000_0000_00d4, 2'd2, 1'b1, 1'b0);
      repeat (8) @(posedge pclk25);
      #1;
      run_check("stale_dest", 48'h1000_0000_00d4, 48'h2000_0000_00e5, 2'd1, 1'b1, 1'b0);
      axi_write(alut_pkg::reg_best_before, 32'hffff_ffff);

      // same hash but different address since a byte pair flip keeps the xor
      for (int k = 0; k < 3; k++)
      begin
         rand_bits(48, a);
         rand_bits(8, r8);
         if (r8[7:0] == 8'd0)
            r8[7:0] = 8'h01;
         b = a ^ {32'd0, r8[7:0], r8[7:0]};
         rand_bits(48, d);
         rand_bits(2, p);
         run_check("collide_first", d, a, p[1:0], 1'b0, 1'b0);
         check_reused("reused_before");
         rand_bits(48, d);
         rand_bits(2, p);
         run_check("collide_second", d, b, p[1:0], 1'b0, 1'b0);
         check_reused("reused_set");
         check_reused("reused_cleared");
         check_inv();
      end

      // second command while busy with the source as destination so a rerun would show
      for (int k = 0; k < 4; k++)
      begin
         rand_bits(48, a);
         rand_bits(2, p);
         run_check("busy_cmd", a, a, p[1:0], 1'b0, 1'b1);
      end
      check_reused("reused_final");

      @(posedge pclk25);
      @(negedge pclk25);
      #1;   // compare process has drained the queue
      if (name_q.size() == 0)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("compare queue still holds %0d entries at the end", name_q.size());
         $display("TESTS FAILED");
         $fatal(1, "unchecked results");
      end
   end

   // watchdog with a generous bound per check
   initial
   begin
      repeat (limit_cycles) @(posedge pclk25);
      $display("run did not finish within %0d cycles, a handshake hung", limit_cycles);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
   end

endmodule

// File: sim/alut_properties.sv
// concurrent checks on the address checker output vector, age handshake and table writes
`timescale 1ns/1ps

module alut_properties (
   input logic       pclk25,
   input logic       n_p_reset25,
   input logic [4:0] d_port,
   input logic       busy,
   input logic       check_age,       // request to the age checker
   input logic       age_confirmed,   // its answer
   input logic       mem_write        // table write strobe
);

   logic wrote_q;   // learn write already seen in the running check

   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         wrote_q <= 1'b0;
      else if (!busy)
         wrote_q <= 1'b0;   // idle closes the check
      else if (mem_write)
         wrote_q <= 1'b1;
   end

   // the switch bit never goes out together with an ethernet port
   a_dport_exclusive: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      !(d_port[4] && (|d_port[3:0])))
      else $error("d_port %b mixes the switch bit with port bits", d_port);

   a_age_answer: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      check_age |=> age_confirmed)
      else $error("age check request not answered on the next cycle");

   a_age_no_stray: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      age_confirmed |-> $past(check_age))
      else $error("age answer without a request one cycle before");

   // at most one learn write between two idle cycles
   a_single_write: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      mem_write |-> !wrote_q)
      else $error("table written a second time within one check");

endmodule

bind alut_addr_checker alut_properties u_props (
   .pclk25, .n_p_reset25, .d_port, .busy,
   .check_age(age.check_age), .age_confirmed(age.age_confirmed), .mem_write(mem.write)
);

// File: design/alut_top.sv
// address lookup unit top level joining the register slave, checker, age checker and table
`timescale 1ns/1ps

module alut_top #(
   parameter int table_depth = 256
) (
   input  logic         pclk25,
   input  logic         n_p_reset25,
   input  logic [7:0]   awaddr,
   input  logic         awvalid,
   output logic         awready,
   input  logic [31:0]  wdata,
   input  logic [3:0]   wstrb,
   input  logic         wvalid,
   output logic         wready,
   output logic [1:0]   bresp,
   output logic         bvalid,
   input  logic         bready,
   input  logic [7:0]   araddr,
   input  logic         arvalid,
   output logic         arready,
   output logic [31:0]  rdata,
   output logic [1:0]   rresp,
   output logic         rvalid,
   input  logic         rready
);

   alut_pkg::cmd_e                command;
   logic [alut_pkg::addr_w-1:0]   mac_addr, d_addr, s_addr, lst_inv_addr;
   logic [alut_pkg::port_w-1:0]   s_port, lst_inv_port;
   logic [31:0]                   best_before;
   logic [alut_pkg::time_w-1:0]   curr_time;
   logic [4:0]                    d_port;
   logic                          clear_reused, busy, reused;

   alut_mem_if #(.table_depth(table_depth)) mem_bus ();
   alut_age_if                              age_bus ();

   alut_regs u_regs (.*);

   alut_addr_checker #(.table_depth(table_depth)) u_checker (
      .pclk25, .n_p_reset25, .command, .mac_addr, .d_addr, .s_addr, .s_port,
      .curr_time, .clear_reused, .mem(mem_bus), .age(age_bus),
      .d_port, .busy, .reused, .lst_inv_addr, .lst_inv_port
   );

   alut_age_checker u_age (
      .pclk25, .n_p_reset25, .curr_time, .best_before, .age(age_bus)
   );

   alut_mem #(.table_depth(table_depth)) u_mem (
      .pclk25, .n_p_reset25, .mem(mem_bus)
   );

endmodule

// File: design/alut_regs.sv
// axi4-lite register slave holding frame and config registers and the timestamp counter
`timescale 1ns/1ps

module alut_regs (
   input  logic                          pclk25,
   input  logic                          n_p_reset25,
   input  logic [7:0]                    awaddr,
   input  logic                          awvalid,
   output logic                          awready,
   input  logic [31:0]                   wdata,
   input  logic [3:0]                    wstrb,
   input  logic                          wvalid,
   output logic                          wready,
   output logic [1:0]                    bresp,
   output logic                          bvalid,
   input  logic                          bready,
   input  logic [7:0]                    araddr,
   input  logic                          arvalid,
   output logic                          arready,
   output logic [31:0]                   rdata,
   output logic [1:0]                    rresp,
   output logic                          rvalid,
   input  logic                          rready,
   output alut_pkg::cmd_e                command,
   output logic [alut_pkg::addr_w-1:0]   mac_addr,
   output logic [alut_pkg::addr_w-1:0]   d_addr,
   output logic [alut_pkg::addr_w-1:0]   s_addr,
   output logic [alut_pkg::port_w-1:0]   s_port,
   output logic [31:0]                   best_before,
   output logic [alut_pkg::time_w-1:0]   curr_time,
   output logic                          clear_reused,
   input  logic [4:0]                    d_port,
   input  logic                          busy,
   input  logic                          reused,
   input  logic [alut_pkg::addr_w-1:0]   lst_inv_addr,
   input  logic [alut_pkg::port_w-1:0]   lst_inv_port
);

   logic        wr_en, rd_en;   // accepted write / read this cycle
   logic [31:0] wmask;          // byte enables spread to bits
   logic [31:0] rd_val;

   function automatic logic [31:0] merge32(input logic [31:0] cur, input logic [31:0] m,
                                           input logic [31:0] d);
      return (cur & ~m) | (d & m);
   endfunction

   function automatic logic [15:0] merge16(input logic [15:0] cur, input logic [31:0] m,
                                           input logic [31:0] d);
      return (cur & ~m[15:0]) | (d[15:0] & m[15:0]);
   endfunction

   // ------------------------------------------------------------
   // axi handshakes, one transaction per channel
   // ------------------------------------------------------------
   assign wr_en   = awvalid & wvalid & ~bvalid;   // aw and w taken together
   assign awready = wr_en;
   assign wready  = wr_en;
   assign bresp   = 2'b00;                        // always okay
   assign arready = ~rvalid;
   assign rd_en   = arvalid & arready;
   assign rresp   = 2'b00;
   assign wmask   = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
   assign clear_reused = rd_en && (araddr == alut_pkg::reg_reused);

   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         if (wr_en)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (rd_en)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // frame and config registers
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         d_addr      <= '0;
         s_addr      <= '0;
         s_port      <= '0;
         mac_addr    <= '0;
         best_before <= '0;
      end
      else if (wr_en)
      begin
         case (awaddr)
            alut_pkg::reg_daddr_lo:    d_addr[31:0]   <= merge32(d_addr[31:0], wmask, wdata);
            alut_pkg::reg_daddr_hi:    d_addr[47:32]  <= merge16(d_addr[47:32], wmask, wdata);
            alut_pkg::reg_saddr_lo:    s_addr[31:0]   <= merge32(s_addr[31:0], wmask, wdata);
            alut_pkg::reg_saddr_hi:    s_addr[47:32]  <= merge16(s_addr[47:32], wmask, wdata);
            alut_pkg::reg_sport:       s_port <= (s_port & ~wmask[1:0]) | (wdata[1:0] & wmask[1:0]);
            alut_pkg::reg_mac_lo:      mac_addr[31:0] <= merge32(mac_addr[31:0], wmask, wdata);
            alut_pkg::reg_mac_hi:      mac_addr[47:32] <= merge16(mac_addr[47:32], wmask, wdata);
            alut_pkg::reg_best_before: best_before    <= merge32(best_before, wmask, wdata);
            default: ;   // unmapped or read only
         endcase
      end
   end

   // command pulse and free running timestamp
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         command   <= alut_pkg::cmd_none;
         curr_time <= '0;
      end
      else
      begin
         curr_time <= curr_time + 1'b1;
         if (wr_en && awaddr == alut_pkg::reg_cmd && wstrb[0] && wdata[1:0] == 2'd1 &&
             !busy && command == alut_pkg::cmd_none)
            command <= alut_pkg::cmd_check;   // dropped while a check runs
         else
            command <= alut_pkg::cmd_none;
      end
   end

   // ------------------------------------------------------------
   // read data
   // ------------------------------------------------------------
   always_comb
   begin
      case (araddr)
         alut_pkg::reg_daddr_lo:    rd_val = d_addr[31:0];
         alut_pkg::reg_daddr_hi:    rd_val = {16'd0, d_addr[47:32]};
         alut_pkg::reg_saddr_lo:    rd_val = s_addr[31:0];
         alut_pkg::reg_saddr_hi:    rd_val = {16'd0, s_addr[47:32]};
         alut_pkg::reg_sport:       rd_val = {30'd0, s_port};
         alut_pkg::reg_mac_lo:      rd_val = mac_addr[31:0];
         alut_pkg::reg_mac_hi:      rd_val = {16'd0, mac_addr[47:32]};
         alut_pkg::reg_best_before: rd_val = best_before;
         alut_pkg::reg_status:      rd_val = {31'd0, busy};
         alut_pkg::reg_dport:       rd_val = {27'd0, d_port};
         alut_pkg::reg_reused:      rd_val = {31'd0, reused};
         alut_pkg::reg_inv_lo:      rd_val = lst_inv_addr[31:0];
         alut_pkg::reg_inv_hi:      rd_val = {16'd0, lst_inv_addr[47:32]};
         alut_pkg::reg_inv_port:    rd_val = {30'd0, lst_inv_port};
         alut_pkg::reg_time:        rd_val = curr_time;
         default:                   rd_val = '0;   // unmapped reads zero
      endcase
   end

   always_ff @(posedge pclk25)
   begin
      if (rd_en)
         rdata <= rd_val;
   end

endmodule

// File: design/alut_addr_checker.sv
// address checker FSM that looks up the destination port and learns the source entry
`timescale 1ns/1ps

module alut_addr_checker #(
   parameter int table_depth = 256
) (
   input  logic                          pclk25,
   input  logic                          n_p_reset25,
   input  alut_pkg::cmd_e                command,        // one cycle check pulse
   input  logic [alut_pkg::addr_w-1:0]   mac_addr,       // own address of the switch
   input  logic [alut_pkg::addr_w-1:0]   d_addr,
   input  logic [alut_pkg::addr_w-1:0]   s_addr,
   input  logic [alut_pkg::port_w-1:0]   s_port,
   input  logic [alut_pkg::time_w-1:0]   curr_time,
   input  logic                          clear_reused,   // read of reg_reused
   alut_mem_if.master                    mem,
   alut_age_if.requester                 age,
   output logic [4:0]                    d_port,
   output logic                          busy,
   output logic                          reused,
   output logic [alut_pkg::addr_w-1:0]   lst_inv_addr,
   output logic [alut_pkg::port_w-1:0]   lst_inv_port
);

   localparam int hash_w = $clog2(table_depth);

   alut_pkg::chk_state_e  state, nxt_state;
   alut_pkg::alut_entry_t dent;             // destination entry held for the check
   logic                  hit;              // entry valid and in date so far
   logic [hash_w-1:0]     d_hash, s_hash;
   logic [4:0]            src_bit;          // sending port, never sent back
   logic [4:0]            mem_bit;          // stored port as one hot

   // xor of the six address bytes
   function automatic logic [hash_w-1:0] fold(input logic [alut_pkg::addr_w-1:0] a);
      logic [7:0] h;
      h = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40];
      return h[hash_w-1:0];
   endfunction

   assign d_hash  = fold(d_addr);
   assign s_hash  = fold(s_addr);
   assign src_bit = 5'd1 << s_port;
   assign mem_bit = 5'd1 << dent.port;
   assign busy    = (state != alut_pkg::idle);

   // ------------------------------------------------------------
   // check sequence
   // ------------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         alut_pkg::idle:      if (command == alut_pkg::cmd_check) nxt_state = alut_pkg::mac_chk;
         alut_pkg::mac_chk:   nxt_state = (d_addr == mac_addr) ? alut_pkg::idle
                                                               : alut_pkg::read_dest;
         alut_pkg::read_dest: nxt_state = alut_pkg::valid_chk;
         alut_pkg::valid_chk: nxt_state = alut_pkg::age_chk;
         alut_pkg::age_chk:   if (age.age_confirmed) nxt_state = alut_pkg::addr_chk;
         alut_pkg::addr_chk:  nxt_state = alut_pkg::read_src;
         alut_pkg::read_src:  nxt_state = alut_pkg::write_src;
         default:             nxt_state = alut_pkg::idle;   // write_src ends the check
      endcase
   end

   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         state <= alut_pkg::idle;
      else
         state <= nxt_state;
   end

   // table port, source hash only while learning
   assign mem.addr  = (state == alut_pkg::read_src || state == alut_pkg::write_src) ? s_hash
                                                                                     : d_hash;
   assign mem.write = (state == alut_pkg::write_src);
   assign mem.wdata = '{valid: 1'b1, last_accessed: curr_time, port: s_port, addr: s_addr};

   always_ff @(posedge pclk25)
   begin
      if (state == alut_pkg::read_dest)
         dent <= mem.rdata;   // capture destination entry
   end

   assign age.last_accessed = dent.last_accessed;

   // ------------------------------------------------------------
   // destination port decision
   // ------------------------------------------------------------
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         d_port        <= alut_pkg::dport_all;
         hit           <= 1'b0;
         age.check_age <= 1'b0;
      end
      else
      begin
         age.check_age <= (state == alut_pkg::valid_chk);   // high in first age_chk cycle
         case (state)
            alut_pkg::mac_chk:
               if (d_addr == mac_addr)
                  d_port <= alut_pkg::dport_mac;
            alut_pkg::valid_chk: hit <= dent.valid;
            alut_pkg::age_chk:
               if (age.age_confirmed)
                  hit <= hit & age.age_ok;   // stale entry counts as a miss
            alut_pkg::addr_chk:
               if (hit && dent.addr == d_addr)
                  d_port <= mem_bit & ~src_bit;
               else
                  d_port <= alut_pkg::dport_all & ~src_bit;   // broadcast
            default: ;
         endcase
      end
   end

   // overwritten entry tracking, set wins over the read clear
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (state == alut_pkg::read_src && mem.rdata.valid && mem.rdata.addr != s_addr)
      begin
         reused       <= 1'b1;
         lst_inv_addr <= mem.rdata.addr;
         lst_inv_port <= mem.rdata.port;
      end
      else if (clear_reused)
         reused <= 1'b0;   // last invalidated entry kept
   end

endmodule

// File: design/alut_age_checker.sv
// age checker that decides whether a table entry is still within its best before limit
`timescale 1ns/1ps

module alut_age_checker (
   input  logic                          pclk25,
   input  logic                          n_p_reset25,
   input  logic [alut_pkg::time_w-1:0]   curr_time,
   input  logic [31:0]                   best_before,   // allowed age in ticks
   alut_age_if.responder                 age
);

   logic [alut_pkg::time_w-1:0] elapsed;   // wraps with the time counter

   assign elapsed = curr_time - age.last_accessed;

   // answer one cycle after the request
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         age.age_confirmed <= 1'b0;
         age.age_ok        <= 1'b0;
      end
      else
      begin
         age.age_confirmed <= age.check_age;
         if (age.check_age)
            age.age_ok <= (elapsed <= best_before);
      end
   end

endmodule

// File: design/alut_mem.sv
// lookup table of address entries with combinational read and clocked write
`timescale 1ns/1ps

module alut_mem #(
   parameter int table_depth = 256
) (
   input  logic       pclk25,
   input  logic       n_p_reset25,
   alut_mem_if.slave  mem
);

   alut_pkg::alut_entry_t   table_q [table_depth];   // payload, valid bit ignored
   logic [table_depth-1:0]  valid_q;                 // per entry valid, cleared on reset

   always_ff @(posedge pclk25)
   begin
      if (mem.write)
         table_q[mem.addr] <= mem.wdata;
   end

   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         valid_q <= '0;
      else if (mem.write)
         valid_q[mem.addr] <= mem.wdata.valid;
   end

   // entry with its live valid bit
   always_comb
   begin
      mem.rdata       = table_q[mem.addr];
      mem.rdata.valid = valid_q[mem.addr];
   end

endmodule

// File: design/alut_ifs.sv
// table access and age check interfaces between the address checker and its helpers
`timescale 1ns/1ps

interface alut_mem_if #(
   parameter int table_depth = 256
);
   logic [$clog2(table_depth)-1:0] addr;    // hashed table index
   logic                           write;   // write strobe, takes effect at the edge
   alut_pkg::alut_entry_t          wdata;
   alut_pkg::alut_entry_t          rdata;   // entry at addr, same cycle

   modport master (output addr, output write, output wdata, input rdata);
   modport slave  (input addr, input write, input wdata, output rdata);
endinterface

interface alut_age_if;
   logic                          check_age;       // one cycle request
   logic [alut_pkg::time_w-1:0]   last_accessed;   // timestamp under test
   logic                          age_confirmed;   // one cycle after check_age
   logic                          age_ok;          // entry still in date

   modport requester (output check_age, output last_accessed,
                      input age_confirmed, input age_ok);
   modport responder (input check_age, input last_accessed,
                      output age_confirmed, output age_ok);
endinterface

// File: design/alut_pkg.sv
// shared widths, table entry layout, opcodes and register map of the address lookup unit
package alut_pkg;

   localparam int addr_w = 48;   // ethernet mac address
   localparam int time_w = 32;   // timestamp of last access
   localparam int port_w = 2;    // encoded port number, four ports

   // one table entry, valid bit on top
   typedef struct packed {
      logic              valid;
      logic [time_w-1:0] last_accessed;
      logic [port_w-1:0] port;
      logic [addr_w-1:0] addr;
   } alut_entry_t;

   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1
   } cmd_e;

   typedef enum logic [2:0] {
      idle, mac_chk, read_dest, valid_chk, age_chk, addr_chk, read_src, write_src
   } chk_state_e;

   localparam logic [4:0] dport_mac = 5'b1_0000;   // frame is for the switch itself
   localparam logic [4:0] dport_all = 5'b0_1111;   // broadcast to all ethernet ports

   // ------------------------------------------------------------
   // register offsets
   // ------------------------------------------------------------
   localparam logic [7:0] reg_cmd         = 8'h00;
   localparam logic [7:0] reg_daddr_lo    = 8'h04;
   localparam logic [7:0] reg_daddr_hi    = 8'h08;
   localparam logic [7:0] reg_saddr_lo    = 8'h0C;
   localparam logic [7:0] reg_saddr_hi    = 8'h10;
   localparam logic [7:0] reg_sport       = 8'h14;
   localparam logic [7:0] reg_mac_lo      = 8'h18;
   localparam logic [7:0] reg_mac_hi      = 8'h1C;
   localparam logic [7:0] reg_best_before = 8'h20;
   localparam logic [7:0] reg_status      = 8'h24;   // bit 0 busy
   localparam logic [7:0] reg_dport       = 8'h28;
   localparam logic [7:0] reg_reused      = 8'h2C;   // cleared on read
   localparam logic [7:0] reg_inv_lo      = 8'h30;
   localparam logic [7:0] reg_inv_hi      = 8'h34;
   localparam logic [7:0] reg_inv_port    = 8'h38;
   localparam logic [7:0] reg_time        = 8'h3C;

endpackage
